// File: hdl/decodePkg.sv
package decodePkg;

typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
} rFields_t;

typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [15:0] imm;
} iFields_t;

typedef struct packed {
    logic [5:0] opcode;
    logic [25:0] target;
} jFields_t;

// one instruction word, read as R-type or as I/J-type
typedef union packed {
    rFields_t r;
    iFields_t i;
    jFields_t j;
} instrWord_u;

localparam logic [5:0] opSpecial = 6'b000000;
localparam logic [5:0] opRegimm = 6'b000001;
localparam logic [5:0] opJ = 6'b000010;
localparam logic [5:0] opJal = 6'b000011;
localparam logic [5:0] opBeq = 6'b000100;
localparam logic [5:0] opBne = 6'b000101;
localparam logic [5:0] opBlez = 6'b000110;
localparam logic [5:0] opBgtz = 6'b000111;
localparam logic [5:0] opAddi = 6'b001000;
localparam logic [5:0] opAddiu = 6'b001001;
localparam logic [5:0] opSlti = 6'b001010;
localparam logic [5:0] opSltiu = 6'b001011;
localparam logic [5:0] opAndi = 6'b001100;
localparam logic [5:0] opOri = 6'b001101;
localparam logic [5:0] opXori = 6'b001110;
localparam logic [5:0] opLui = 6'b001111;
localparam logic [5:0] opBeql = 6'b010100;
localparam logic [5:0] opBnel = 6'b010101;
localparam logic [5:0] opBlezl = 6'b010110;
localparam logic [5:0] opBgtzl = 6'b010111;
localparam logic [5:0] opLb = 6'b100000;
localparam logic [5:0] opLh = 6'b100001;
localparam logic [5:0] opLw = 6'b100011;
localparam logic [5:0] opLbu = 6'b100100;
localparam logic [5:0] opLhu = 6'b100101;
localparam logic [5:0] opSb = 6'b101000;
localparam logic [5:0] opSh = 6'b101001;
localparam logic [5:0] opSw = 6'b101011;

localparam logic [5:0] fnSll = 6'b000000;
localparam logic [5:0] fnSrl = 6'b000010;
localparam logic [5:0] fnSra = 6'b000011;
localparam logic [5:0] fnSllv = 6'b000100;
localparam logic [5:0] fnSrlv = 6'b000110;
localparam logic [5:0] fnSrav = 6'b000111;
localparam logic [5:0] fnJr = 6'b001000;
localparam logic [5:0] fnJalr = 6'b001001;
localparam logic [5:0] fnSyscall = 6'b001100;
localparam logic [5:0] fnBreak = 6'b001101;
localparam logic [5:0] fnMfhi = 6'b010000;
localparam logic [5:0] fnMthi = 6'b010001;
localparam logic [5:0] fnMflo = 6'b010010;
localparam logic [5:0] fnMtlo = 6'b010011;
localparam logic [5:0] fnMult = 6'b011000;
localparam logic [5:0] fnMultu = 6'b011001;
localparam logic [5:0] fnDiv = 6'b011010;
localparam logic [5:0] fnDivu = 6'b011011;
localparam logic [5:0] fnAdd = 6'b100000;
localparam logic [5:0] fnAddu = 6'b100001;
localparam logic [5:0] fnSub = 6'b100010;
localparam logic [5:0] fnSubu = 6'b100011;
localparam logic [5:0] fnAnd = 6'b100100;
localparam logic [5:0] fnOr = 6'b100101;
localparam logic [5:0] fnXor = 6'b100110;
localparam logic [5:0] fnNor = 6'b100111;
localparam logic [5:0] fnSlt = 6'b101010;
localparam logic [5:0] fnSltu = 6'b101011;

// REGIMM branches, keyed on the rt field
localparam logic [4:0] rtBltz = 5'b00000;
localparam logic [4:0] rtBgez = 5'b00001;
localparam logic [4:0] rtBltzl = 5'b00010;
localparam logic [4:0] rtBgezl = 5'b00011;
localparam logic [4:0] rtBltzal = 5'b10000;
localparam logic [4:0] rtBgezal = 5'b10001;
localparam logic [4:0] rtBltzall = 5'b10010;
localparam logic [4:0] rtBgezall = 5'b10011;

typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor,
    aluShiftLeft, aluShiftRight, aluArithShiftRight, aluSlt, aluSltu
} aluOp_e;

typedef enum logic [2:0] {
    mulDisabled, mulMult, mulMultu, mulDiv, mulDivu, mulSetHi, mulSetLo
} mulOp_e;

typedef enum logic [2:0] {
    cmpNone, cmpEqual, cmpNotEqual, cmpLessThanZero,
    cmpGreaterEqualZero, cmpLessEqualZero, cmpGreaterThanZero
} cmpOp_e;

typedef enum logic [2:0] {grfNone, grfAlu, grfMem, grfMul, grfPc} grfSrc_e;
typedef enum logic [1:0] {memByte, memHalf, memWord} memWidth_e;
typedef enum logic [1:0] {excNone, excSyscall, excBreak, excUnknown} exception_e;
typedef enum logic {absJumpRegister, absJumpImmediate} absJumpLoc_e;

typedef struct packed {
    logic [4:0] regRead1;
    logic [4:0] regRead2;
    logic [4:0] destinationRegister;
    logic [31:0] immediate;
    logic aluSrc;             // immediate replaces second operand
    aluOp_e aluCtrl;
    logic checkOverflow;
    mulOp_e mulCtrl;
    logic mulEnable;
    logic mulOutputSel;       // 1 selects hi
    cmpOp_e cmpCtrl;
    logic branch;
    logic branchLikely;
    logic absJump;
    absJumpLoc_e absJumpLoc;
    logic memLoad;
    logic memStore;
    memWidth_e memWidthCtrl;
    logic memReadSignExtend;
    grfSrc_e grfWriteSource;
    exception_e generateException;
} controlSignals_t;

typedef struct packed {
    logic hit;
    controlSignals_t ctrl;
} partialDecode_t;

localparam controlSignals_t kControlNop = '{
    regRead1: 5'd0,
    regRead2: 5'd0,
    destinationRegister: 5'd0,
    immediate: 32'd0,
    aluSrc: 1'b0,
    aluCtrl: aluAdd,
    checkOverflow: 1'b0,
    mulCtrl: mulDisabled,
    mulEnable: 1'b0,
    mulOutputSel: 1'b0,
    cmpCtrl: cmpNone,
    branch: 1'b0,
    branchLikely: 1'b0,
    absJump: 1'b0,
    absJumpLoc: absJumpRegister,
    memLoad: 1'b0,
    memStore: 1'b0,
    memWidthCtrl: memByte,
    memReadSignExtend: 1'b0,
    grfWriteSource: grfNone,
    generateException: excNone
};

endpackage

// File: hdl/specialOpDecoder.sv
module specialOpDecoder
(
    input decodePkg::instrWord_u word,
    output decodePkg::partialDecode_t result
);

decodePkg::rFields_t rView;
decodePkg::aluOp_e aluOp;
decodePkg::mulOp_e mulOp;
decodePkg::controlSignals_t ctrl;
logic known;

assign rView = word.r;

// operation per function code, shared by the forms below
always_comb
begin
    aluOp = decodePkg::aluAdd;
    mulOp = decodePkg::mulDisabled;
    case (rView.funct)
        decodePkg::fnSub, decodePkg::fnSubu: aluOp = decodePkg::aluSub;
        decodePkg::fnAnd: aluOp = decodePkg::aluAnd;
        decodePkg::fnOr: aluOp = decodePkg::aluOr;
        decodePkg::fnNor: aluOp = decodePkg::aluNor;
        decodePkg::fnXor: aluOp = decodePkg::aluXor;
        decodePkg::fnSlt: aluOp = decodePkg::aluSlt;
        decodePkg::fnSltu: aluOp = decodePkg::aluSltu;
        decodePkg::fnSll, decodePkg::fnSllv: aluOp = decodePkg::aluShiftLeft;
        decodePkg::fnSrl, decodePkg::fnSrlv: aluOp = decodePkg::aluShiftRight;
        decodePkg::fnSra, decodePkg::fnSrav: aluOp = decodePkg::aluArithShiftRight;
        decodePkg::fnMult: mulOp = decodePkg::mulMult;
        decodePkg::fnMultu: mulOp = decodePkg::mulMultu;
        decodePkg::fnDiv: mulOp = decodePkg::mulDiv;
        decodePkg::fnDivu: mulOp = decodePkg::mulDivu;
        decodePkg::fnMthi: mulOp = decodePkg::mulSetHi;
        decodePkg::fnMtlo: mulOp = decodePkg::mulSetLo;
        default: aluOp = decodePkg::aluAdd;
    endcase
end

always_comb
begin
    ctrl = decodePkg::kControlNop;
    known = 1'b1;
    case (rView.funct)
        decodePkg::fnAdd, decodePkg::fnAddu, decodePkg::fnSub, decodePkg::fnSubu,
        decodePkg::fnAnd, decodePkg::fnOr, decodePkg::fnXor, decodePkg::fnNor,
        decodePkg::fnSlt, decodePkg::fnSltu:
        begin
            ctrl.regRead1 = rView.rs;
            ctrl.regRead2 = rView.rt;
            ctrl.destinationRegister = rView.rd;
            ctrl.grfWriteSource = decodePkg::grfAlu;
            ctrl.aluCtrl = aluOp;
            ctrl.checkOverflow = (rView.funct == decodePkg::fnAdd) ||
                                 (rView.funct == decodePkg::fnSub);
        end
        decodePkg::fnSll, decodePkg::fnSrl, decodePkg::fnSra:
        begin
            ctrl.regRead1 = rView.rt;   // shifted value
            ctrl.destinationRegister = rView.rd;
            ctrl.grfWriteSource = decodePkg::grfAlu;
            ctrl.aluCtrl = aluOp;
            ctrl.aluSrc = 1'b1;
            ctrl.immediate = {27'd0, rView.shamt};
        end
        decodePkg::fnSllv, decodePkg::fnSrlv, decodePkg::fnSrav:
        begin
            ctrl.regRead1 = rView.rt;
            ctrl.regRead2 = rView.rs;   // shift amount
            ctrl.destinationRegister = rView.rd;
            ctrl.grfWriteSource = decodePkg::grfAlu;
            ctrl.aluCtrl = aluOp;
        end
        decodePkg::fnMult, decodePkg::fnMultu, decodePkg::fnDiv, decodePkg::fnDivu:
        begin
            ctrl.regRead1 = rView.rs;
            ctrl.regRead2 = rView.rt;
            ctrl.mulCtrl = mulOp;
        end
        decodePkg::fnMthi, decodePkg::fnMtlo:
        begin
            ctrl.regRead1 = rView.rs;
            ctrl.mulCtrl = mulOp;
        end
        decodePkg::fnMfhi, decodePkg::fnMflo:
        begin
            ctrl.destinationRegister = rView.rd;
            ctrl.grfWriteSource = decodePkg::grfMul;
            ctrl.mulOutputSel = rView.funct == decodePkg::fnMfhi;
        end
        decodePkg::fnJr, decodePkg::fnJalr:
        begin
            ctrl.regRead1 = rView.rs;
            ctrl.absJump = 1'b1;
            ctrl.absJumpLoc = decodePkg::absJumpRegister;
            if (rView.funct == decodePkg::fnJalr)
            begin
                ctrl.grfWriteSource = decodePkg::grfPc;
                ctrl.destinationRegister = rView.rd;   // jalr links to rd
            end
        end
        decodePkg::fnSyscall: ctrl.generateException = decodePkg::excSyscall;
        decodePkg::fnBreak: ctrl.generateException = decodePkg::excBreak;
        default: known = 1'b0;
    endcase
end

assign result = '{hit: known && (rView.opcode == decodePkg::opSpecial), ctrl: ctrl};

endmodule

// File: hdl/primaryOpDecoder.sv
module primaryOpDecoder
(
    input decodePkg::instrWord_u word,
    output decodePkg::partialDecode_t result
);

localparam logic [4:0] linkRegister = 5'd31;

decodePkg::iFields_t iView;
decodePkg::jFields_t jView;
logic [31:0] signImm;
logic [31:0] zeroImm;
logic [31:0] upperImm;
logic [31:0] targetImm;
decodePkg::controlSignals_t ctrl;
logic known;

function automatic decodePkg::memWidth_e widthOf(input logic [5:0] opcode);
    case (opcode)
        decodePkg::opLb, decodePkg::opLbu, decodePkg::opSb: return decodePkg::memByte;
        decodePkg::opLh, decodePkg::opLhu, decodePkg::opSh: return decodePkg::memHalf;
        default: return decodePkg::memWord;
    endcase
endfunction

assign iView = word.i;
assign jView = word.j;
assign signImm = {{16{iView.imm[15]}}, iView.imm};
assign zeroImm = {16'd0, iView.imm};
assign upperImm = {iView.imm, 16'd0};      // lui
assign targetImm = {6'd0, jView.target};

always_comb
begin
    ctrl = decodePkg::kControlNop;
    known = 1'b1;
    case (iView.opcode)
        decodePkg::opAddi, decodePkg::opAddiu, decodePkg::opSlti, decodePkg::opSltiu,
        decodePkg::opAndi, decodePkg::opOri, decodePkg::opXori, decodePkg::opLui:
        begin
            ctrl.regRead1 = iView.rs;
            ctrl.destinationRegister = iView.rt;
            ctrl.grfWriteSource = decodePkg::grfAlu;
            ctrl.aluSrc = 1'b1;
            ctrl.immediate = signImm;
            ctrl.checkOverflow = iView.opcode == decodePkg::opAddi;
            case (iView.opcode)
                decodePkg::opSlti: ctrl.aluCtrl = decodePkg::aluSlt;
                decodePkg::opSltiu: ctrl.aluCtrl = decodePkg::aluSltu;
                decodePkg::opAndi:
                begin
                    ctrl.aluCtrl = decodePkg::aluAnd;
                    ctrl.immediate = zeroImm;
                end
                decodePkg::opOri:
                begin
                    ctrl.aluCtrl = decodePkg::aluOr;
                    ctrl.immediate = zeroImm;
                end
                decodePkg::opXori:
                begin
                    ctrl.aluCtrl = decodePkg::aluXor;
                    ctrl.immediate = zeroImm;
                end
                decodePkg::opLui: ctrl.immediate = upperImm;   // added to rs, normally $zero
                default: ctrl.aluCtrl = decodePkg::aluAdd;
            endcase
        end
        decodePkg::opLb, decodePkg::opLh, decodePkg::opLw, decodePkg::opLbu, decodePkg::opLhu:
        begin
            ctrl.regRead1 = iView.rs;
            ctrl.destinationRegister = iView.rt;
            ctrl.grfWriteSource = decodePkg::grfMem;
            ctrl.memLoad = 1'b1;
            ctrl.immediate = signImm;
            ctrl.memWidthCtrl = widthOf(iView.opcode);
            ctrl.memReadSignExtend = (iView.opcode == decodePkg::opLb) ||
                                     (iView.opcode == decodePkg::opLh);
        end
        decodePkg::opSb, decodePkg::opSh, decodePkg::opSw:
        begin
            ctrl.regRead1 = iView.rs;
            ctrl.regRead2 = iView.rt;   // store data
            ctrl.memStore = 1'b1;
            ctrl.immediate = signImm;
            ctrl.memWidthCtrl = widthOf(iView.opcode);
        end
        decodePkg::opBeq, decodePkg::opBne, decodePkg::opBeql, decodePkg::opBnel:
        begin
            ctrl.regRead1 = iView.rs;
            ctrl.regRead2 = iView.rt;
            ctrl.branch = 1'b1;
            ctrl.immediate = signImm;
            ctrl.cmpCtrl = (iView.opcode == decodePkg::opBeq || iView.opcode == decodePkg::opBeql)
                ? decodePkg::cmpEqual : decodePkg::cmpNotEqual;
            ctrl.branchLikely = (iView.opcode == decodePkg::opBeql) ||
                                (iView.opcode == decodePkg::opBnel);
        end
        decodePkg::opBlez, decodePkg::opBgtz, decodePkg::opBlezl, decodePkg::opBgtzl:
        begin
            ctrl.regRead1 = iView.rs;
            ctrl.branch = 1'b1;
            ctrl.immediate = signImm;
            ctrl.cmpCtrl = (iView.opcode == decodePkg::opBlez || iView.opcode == decodePkg::opBlezl)
                ? decodePkg::cmpLessEqualZero : decodePkg::cmpGreaterThanZero;
            ctrl.branchLikely = (iView.opcode == decodePkg::opBlezl) ||
                                (iView.opcode == decodePkg::opBgtzl);
        end
        decodePkg::opRegimm:
        begin
            ctrl.regRead1 = iView.rs;
            ctrl.branch = 1'b1;
            ctrl.immediate = signImm;
            // rt bit 0 picks the compare, bit 1 likely, bit 4 link
            ctrl.cmpCtrl = iView.rt[0] ? decodePkg::cmpGreaterEqualZero
                                       : decodePkg::cmpLessThanZero;
            ctrl.branchLikely = iView.rt[1];
            if (iView.rt[4])
            begin
                ctrl.grfWriteSource = decodePkg::grfPc;
                ctrl.destinationRegister = linkRegister;
            end
            known = iView.rt inside {decodePkg::rtBltz, decodePkg::rtBgez, decodePkg::rtBltzl,
                                     decodePkg::rtBgezl, decodePkg::rtBltzal, decodePkg::rtBgezal,
                                     decodePkg::rtBltzall, decodePkg::rtBgezall};
        end
        decodePkg::opJ, decodePkg::opJal:
        begin
            ctrl.absJump = 1'b1;
            ctrl.absJumpLoc = decodePkg::absJumpImmediate;
            ctrl.immediate = targetImm;
            if (jView.opcode == decodePkg::opJal)
            begin
                ctrl.grfWriteSource = decodePkg::grfPc;
                ctrl.destinationRegister = linkRegister;
            end
        end
        default: known = 1'b0;
    endcase
end

assign result = '{hit: known, ctrl: ctrl};

endmodule

// File: hdl/controlMerge.sv
module controlMerge #(
    parameter bit implementLikely = 1'b1
)(
    input logic clk,
    input logic rstN,
    input logic bubble,
    input decodePkg::partialDecode_t specialResult,
    input decodePkg::partialDecode_t primaryResult,
    output decodePkg::controlSignals_t controls
);

decodePkg::controlSignals_t unknownWord;
decodePkg::controlSignals_t selected;

always_comb
begin
    unknownWord = decodePkg::kControlNop;
    unknownWord.generateException = decodePkg::excUnknown;
end

// at most one decoder claims a word
always_comb
begin
    if (specialResult.hit)
        selected = specialResult.ctrl;
    else if (primaryResult.hit)
        selected = primaryResult.ctrl;
    else
        selected = unknownWord;
    if (!implementLikely && selected.branchLikely)
        selected = unknownWord;   // likely forms not supported
    selected.mulEnable = selected.mulCtrl != decodePkg::mulDisabled;
end

always_ff @(posedge clk or negedge rstN)
begin
    if (!rstN)
        controls <= decodePkg::kControlNop;
    else if (bubble)
        controls <= decodePkg::kControlNop;
    else
        controls <= selected;
end

endmodule

// File: hdl/instructionDecoder.sv
module instructionDecoder #(
    parameter bit implementLikely = 1'b1
)(
    input logic clk,
    input logic rstN,
    input logic [31:0] instruction,
    input logic bubble,
    output decodePkg::controlSignals_t controls
);

decodePkg::instrWord_u word;
decodePkg::partialDecode_t specialResult;
decodePkg::partialDecode_t primaryResult;

assign word = decodePkg::instrWord_u'(instruction);

specialOpDecoder u_specialOpDecoder (
    .word(word),
    .result(specialResult)
);

primaryOpDecoder u_primaryOpDecoder (
    .word(word),
    .result(primaryResult)
);

controlMerge #(
    .implementLikely(implementLikely)
) u_controlMerge (
    .clk(clk),
    .rstN(rstN),
    .bubble(bubble),
    .specialResult(specialResult),
    .primaryResult(primaryResult),
    .controls(controls)
);

endmodule

// File: verification/decoderVectors.svh
`ifndef DECODER_VECTORS_SVH
`define DECODER_VECTORS_SVH

// columns: test name, instruction word, bubble, expected control word

localparam int numVectors = 24;

typedef struct packed {
    logic [31:0] instruction;
    logic bubble;
    decodePkg::controlSignals_t expected;
} vector_t;

string vecName[numVectors];
vector_t vecTable[numVectors];
int vecCount = 0;

task automatic addVector(input string name, input logic [31:0] instr, input logic bub,
                         input decodePkg::controlSignals_t expected);
    vecName[vecCount] = name;
    vecTable[vecCount] = '{instruction: instr, bubble: bub, expected: expected};
    vecCount++;
endtask

// nop with register fields and immediate filled in
function automatic decodePkg::controlSignals_t routed(input logic [4:0] read1,
        input logic [4:0] read2, input logic [4:0] dest, input logic [31:0] imm);
    decodePkg::controlSignals_t c;
    c = decodePkg::kControlNop;
    c.regRead1 = read1;
    c.regRead2 = read2;
    c.destinationRegister = dest;
    c.immediate = imm;
    return c;
endfunction

function automatic decodePkg::controlSignals_t unknownResult();
    decodePkg::controlSignals_t c;
    c = decodePkg::kControlNop;
    c.generateException = decodePkg::excUnknown;
    return c;
endfunction

task automatic loadVectors();
    decodePkg::controlSignals_t e;

    e = routed(5'd1, 5'd2, 5'd3, 32'd0);   // add $3,$1,$2
    e.checkOverflow = 1'b1;
    e.grfWriteSource = decodePkg::grfAlu;
    addVector("add", 32'h00221820, 1'b0, e);

    e = routed(5'd4, 5'd6, 5'd5, 32'd0);   // addu $5,$4,$6
    e.grfWriteSource = decodePkg::grfAlu;
    addVector("addu", 32'h00862821, 1'b0, e);

    e = routed(5'd9, 5'd0, 5'd8, 32'd4);   // sll $8,$9,4
    e.aluSrc = 1'b1;
    e.aluCtrl = decodePkg::aluShiftLeft;
    e.grfWriteSource = decodePkg::grfAlu;
    addVector("sll", 32'h00094100, 1'b0, e);

    e = routed(5'd11, 5'd12, 5'd10, 32'd0);   // srav $10,$11,$12
    e.aluCtrl = decodePkg::aluArithShiftRight;
    e.grfWriteSource = decodePkg::grfAlu;
    addVector("srav", 32'h018B5007, 1'b0, e);

    e = routed(5'd1, 5'd2, 5'd0, 32'd0);
    e.mulCtrl = decodePkg::mulMult;
    e.mulEnable = 1'b1;
    addVector("mult", 32'h00220018, 1'b0, e);

    e = routed(5'd0, 5'd0, 5'd7, 32'd0);
    e.grfWriteSource = decodePkg::grfMul;
    e.mulOutputSel = 1'b1;
    addVector("mfhi", 32'h00003810, 1'b0, e);

    e = routed(5'd5, 5'd0, 5'd4, 32'd0);   // jalr $4,$5
    e.absJump = 1'b1;
    e.absJumpLoc = decodePkg::absJumpRegister;
    e.grfWriteSource = decodePkg::grfPc;
    addVector("jalr", 32'h00A02009, 1'b0, e);

    e = decodePkg::kControlNop;
    e.generateException = decodePkg::excSyscall;
    addVector("syscall", 32'h0000000C, 1'b0, e);

    e = routed(5'd1, 5'd0, 5'd2, 32'hFFFFFFFC);   // addi $2,$1,-4
    e.aluSrc = 1'b1;
    e.checkOverflow = 1'b1;
    e.grfWriteSource = decodePkg::grfAlu;
    addVector("addi", 32'h2022FFFC, 1'b0, e);

    e = routed(5'd3, 5'd0, 5'd4, 32'h00008001);   // zero extended
    e.aluSrc = 1'b1;
    e.aluCtrl = decodePkg::aluAnd;
    e.grfWriteSource = decodePkg::grfAlu;
    addVector("andi", 32'h30648001, 1'b0, e);

    e = routed(5'd0, 5'd0, 5'd6, 32'h12340000);
    e.aluSrc = 1'b1;
    e.grfWriteSource = decodePkg::grfAlu;
    addVector("lui", 32'h3C061234, 1'b0, e);

    e = routed(5'd29, 5'd0, 5'd7, 32'hFFFFFFF8);   // lb $7,-8($29)
    e.memLoad = 1'b1;
    e.memWidthCtrl = decodePkg::memByte;
    e.memReadSignExtend = 1'b1;
    e.grfWriteSource = decodePkg::grfMem;
    addVector("lb", 32'h83A7FFF8, 1'b0, e);

    e = routed(5'd29, 5'd0, 5'd8, 32'd6);
    e.memLoad = 1'b1;
    e.memWidthCtrl = decodePkg::memHalf;
    e.grfWriteSource = decodePkg::grfMem;
    addVector("lhu", 32'h97A80006, 1'b0, e);

    e = routed(5'd2, 5'd9, 5'd0, 32'hFFFFFFF0);   // sw $9,-16($2)
    e.memStore = 1'b1;
    e.memWidthCtrl = decodePkg::memWord;
    addVector("sw", 32'hAC49FFF0, 1'b0, e);

    e = routed(5'd1, 5'd2, 5'd0, 32'hFFFFFFFF);
    e.branch = 1'b1;
    e.cmpCtrl = decodePkg::cmpEqual;
    addVector("beq", 32'h1022FFFF, 1'b0, e);

    e = routed(5'd3, 5'd0, 5'd31, 32'h00000010);   // links to $31
    e.branch = 1'b1;
    e.cmpCtrl = decodePkg::cmpGreaterEqualZero;
    e.grfWriteSource = decodePkg::grfPc;
    addVector("bgezal", 32'h04710010, 1'b0, e);

    e = routed(5'd4, 5'd0, 5'd0, 32'hFFFFFFFE);
    e.branch = 1'b1;
    e.branchLikely = 1'b1;
    e.cmpCtrl = decodePkg::cmpLessThanZero;
    addVector("bltzl", 32'h0482FFFE, 1'b0, e);

    e = routed(5'd0, 5'd0, 5'd0, 32'h03FFFFFF);   // full 26-bit target
    e.absJump = 1'b1;
    e.absJumpLoc = decodePkg::absJumpImmediate;
    addVector("j", 32'h0BFFFFFF, 1'b0, e);

    e = routed(5'd0, 5'd0, 5'd31, 32'h00123456);
    e.absJump = 1'b1;
    e.absJumpLoc = decodePkg::absJumpImmediate;
    e.grfWriteSource = decodePkg::grfPc;
    addVector("jal", 32'h0C123456, 1'b0, e);

    addVector("mfc0", 32'h40026000, 1'b0, unknownResult());
    addVector("teq", 32'h00220034, 1'b0, unknownResult());
    addVector("unusedOpcode", 32'hFC000000, 1'b0, unknownResult());
    addVector("addBubbled", 32'h00221820, 1'b1, decodePkg::kControlNop);

    e = routed(5'd1, 5'd2, 5'd3, 32'd0);   // same add right after the bubble
    e.checkOverflow = 1'b1;
    e.grfWriteSource = decodePkg::grfAlu;
    addVector("addAfterBubble", 32'h00221820, 1'b0, e);
endtask

`endif

// File: verification/decoderTb.sv
module decoderTb;

logic clk;
logic rstN;
logic [31:0] instruction;
logic bubble;
decodePkg::controlSignals_t controls;

`include "decoderVectors.svh"

// reset, two cycles per entry, with slack
localparam int cycleLimit = 10 + 2 * numVectors + 20;

int cycleCount;

instructionDecoder u_instructionDecoder (
    .clk(clk),
    .rstN(rstN),
    .instruction(instruction),
    .bubble(bubble),
    .controls(controls)
);

initial
begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

task automatic checkControls(input string name, input decodePkg::controlSignals_t expected);
    assert (controls === expected)
    else
    begin
        $display("Mismatch in %s: expected %h, actual %h", name, expected, controls);
        $display("Regression failed");
        $fatal(1, "control word check did not match");
    end
endtask

initial
begin
    cycleCount = 0;
    while (cycleCount < cycleLimit)
    begin
        @(posedge clk);
        cycleCount++;
    end
    $display("Timeout: decoder run did not finish within %0d cycles", cycleLimit);
    $display("Regression failed");
    $fatal(1, "simulation stopped by timeout");
end

initial
begin
    int idx;

    rstN = 1'b0;
    bubble = 1'b0;   // word 0 decodes as sll, only reset holds nop
    instruction = 32'd0;
    loadVectors();

    for (idx = 0; idx < 10; idx++)
    begin
        @(negedge clk);
        checkControls("duringReset", decodePkg::kControlNop);
    end
    @(posedge clk);
    rstN <= 1'b1;
    bubble <= 1'b1;   // nop on the first edges after release

    for (idx = 0; idx < 2; idx++)
    begin
        @(negedge clk);
        checkControls("afterReset", decodePkg::kControlNop);
    end

    // entry idx goes in while entry idx-1 is checked at the next negedge
    for (idx = 0; idx <= numVectors; idx++)
    begin
        @(posedge clk);
        if (idx < numVectors)
        begin
            instruction <= vecTable[idx].instruction;
            bubble <= vecTable[idx].bubble;
        end
        @(negedge clk);
        if (idx > 0)
            checkControls(vecName[idx - 1], vecTable[idx - 1].expected);
    end

    $display("Regression passed");
    $finish;
end

endmodule

// File: instructionDecoder.f
+incdir+verification
hdl/decodePkg.sv
hdl/specialOpDecoder.sv
hdl/primaryOpDecoder.sv
hdl/controlMerge.sv
hdl/instructionDecoder.sv
verification/decoderTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module decoderTb -f instructionDecoder.f

output=$(./obj_dir/VdecoderTb)
echo "$output"

echo "$output" | grep -q "Regression passed"
